// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // primary opcodes of the supported subset
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // funct codes decoded under op_special
    localparam logic [5:0] fn_srl = 6'b000010;
    localparam logic [5:0] fn_jr  = 6'b001000;

    // first fetch address after reset
    localparam logic [31:0] reset_vector = 32'hBFC0_0000;
    // a jump here stops the core
    localparam logic [31:0] halt_target  = 32'h0000_0000;

    // instruction rom geometry, in words
    localparam int iram_words     = 4096;
    localparam int iram_addr_bits = $clog2(iram_words);

    // data memory geometry, in words
    localparam int dram_words     = 1024;
    localparam int dram_addr_bits = $clog2(dram_words);

    // word k of the data preload is (k+1) * step, truncated
    localparam logic [31:0] dram_seed_step = 32'h1357_9BDF;

    // r-type tail of an instruction word
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rtype_t;

    // low half is either the r-type tail or the immediate
    typedef union packed {
        rtype_t      r;
        logic [15:0] imm;
    } instr_low_t;

    // decoded view of a 32-bit instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        instr_low_t low;
    } instr_t;

    // one sw event, byte address is word aligned
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    // datapath function select
    typedef enum logic [1:0] {
        alu_addr = 2'd0,
        alu_add  = 2'd1,
        alu_srl  = 2'd2
    } alu_op_t;

endpackage

`default_nettype wire

// ==== logic/srl_2_iram.sv ====
`timescale 1ns/1ps
`default_nettype none

module srl_2_iram import mips_pkg::*; (
    // combinational instruction fetch
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    logic [31:0] instr_ram [iram_words];

    // address after folding around the reset vector
    logic [31:0] folded;

    // field variables used to assemble the program
    logic [31:0] w_addr;
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm;
    int          reg_idx;

    initial begin
        // unused words read as sll r0,r0,0 which decodes as a nop
        for (int n = 0; n < iram_words; n++) begin
            instr_ram[n] = '0;
        end
        w_addr = 32'h0;

        // lw r2..r16 from byte offsets 0x00..0x38
        for (reg_idx = 2; reg_idx <= 16; reg_idx++) begin
            opcode = op_lw;
            rs     = 5'd0;
            rt     = 5'(reg_idx);
            imm    = 16'((reg_idx - 2) * 4);
            instr_ram[w_addr[iram_addr_bits+1:2]] = {opcode, rs, rt, imm};
            w_addr += 4;
        end

        // srl r(i+15), r(i), i for i = 2..15
        for (reg_idx = 2; reg_idx <= 15; reg_idx++) begin
            opcode = op_special;
            rs     = 5'd0;
            rt     = 5'(reg_idx);
            rd     = 5'(reg_idx + 15);
            shamt  = 5'(reg_idx);
            funct  = fn_srl;
            instr_ram[w_addr[iram_addr_bits+1:2]] = {opcode, rs, rt, rd, shamt, funct};
            w_addr += 4;
        end

        // sw r17..r30 to 0x100..0x134
        for (reg_idx = 17; reg_idx <= 30; reg_idx++) begin
            opcode = op_sw;
            rs     = 5'd0;
            rt     = 5'(reg_idx);
            imm    = 16'(16'h100 + (reg_idx - 17) * 4);
            instr_ram[w_addr[iram_addr_bits+1:2]] = {opcode, rs, rt, imm};
            w_addr += 4;
        end

        // jr r0, halts once the delay slot retires
        opcode = op_special;
        rs     = 5'd0;
        rt     = 5'd0;
        rd     = 5'd0;
        shamt  = 5'd0;
        funct  = fn_jr;
        instr_ram[w_addr[iram_addr_bits+1:2]] = {opcode, rs, rt, rd, shamt, funct};
        w_addr += 4;

        // delay slot: addiu r2, r0, 0
        opcode = op_addiu;
        rs     = 5'd0;
        rt     = 5'd2;
        imm    = 16'h0;
        instr_ram[w_addr[iram_addr_bits+1:2]] = {opcode, rs, rt, imm};
    end

    // same as addr % reset_vector, since any 32-bit address is below twice the vector
    always_comb begin
        if (instr_address >= reset_vector) begin
            folded = instr_address - reset_vector;
        end else begin
            folded = instr_address;
        end
    end

    // word index, masked to the rom depth
    assign instr_readdata = instr_ram[folded[iram_addr_bits+1:2]];

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram import mips_pkg::*; (
    input  logic        clk,
    // read side, byte address from the datapath
    input  logic [31:0] addr,
    output logic [31:0] rdata,
    // write side, one word per strobe
    input  logic        store_valid,
    input  store_t      store
);

    logic [31:0] mem [dram_words];

    // word indexes for both ports
    logic [dram_addr_bits-1:0] rd_idx;
    logic [dram_addr_bits-1:0] wr_idx;

    // preload the arithmetic series
    initial begin
        for (int k = 0; k < dram_words; k++) begin
            mem[k] = 32'(k + 1) * dram_seed_step;
        end
    end

    // byte address down to word, wraps at the memory depth
    assign rd_idx = addr[dram_addr_bits+1:2];
    assign wr_idx = store.addr[dram_addr_bits+1:2];

    // read is combinational
    assign rdata = mem[rd_idx];

    // write lands at the end of the execute cycle
    always @(posedge clk) begin
        if (store_valid) begin
            mem[wr_idx] <= store.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    // read ports
    input  logic [4:0]  ra,
    input  logic [4:0]  rb,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    // write port
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // r0 is never written so it always reads zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wdata;
        end
    end

    // combinational reads, no write-through
    // the core never reads and writes the same cycle
    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

endmodule

`default_nettype wire

// ==== logic/alu_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shift import mips_pkg::*; (
    input  alu_op_t     alu_op,
    input  instr_t      instr,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    output logic [31:0] result
);

    logic [31:0] imm_sext;
    logic [31:0] sum;
    logic [31:0] shifted;

    // sign extend the 16-bit immediate
    assign imm_sext = {{16{instr.low.imm[15]}}, instr.low.imm};

    // base plus offset, shared by lw, sw and addiu
    assign sum = rs_value + imm_sext;

    // logical shift, zeros come in from the top
    assign shifted = rt_value >> instr.low.r.shamt;

    always_comb begin
        case (alu_op)
            // only word access exists so drop the byte offset
            alu_addr: result = {sum[31:2], 2'b00};
            // addiu never traps on overflow
            alu_add:  result = sum;
            alu_srl:  result = shifted;
            default:  result = sum;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // instruction fetch
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    // register file
    output logic [4:0]  ra,
    output logic [4:0]  rb,
    output logic        we,
    output logic [4:0]  wa,
    output logic [31:0] wdata,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    // datapath
    output alu_op_t     alu_op,
    output instr_t      instr,
    input  logic [31:0] result,
    // data memory
    input  logic [31:0] mem_rdata,
    output logic        store_valid,
    output store_t      store,
    output logic        halted
);

    // two cycles per instruction
    typedef enum logic {
        st_fetch = 1'b0,
        st_exec  = 1'b1
    } state_t;

    state_t      state;
    logic [31:0] pc;
    // instruction latched in the fetch cycle
    instr_t      ir;

    // jr target waits here while the delay slot runs
    logic        pending_jump;
    logic [31:0] pending_target;

    // decode
    logic        in_exec;
    logic        is_lw;
    logic        is_sw;
    logic        is_addiu;
    logic        is_srl;
    logic        is_jr;

    assign in_exec  = (state == st_exec);
    assign is_lw    = (ir.opcode == op_lw);
    assign is_sw    = (ir.opcode == op_sw);
    assign is_addiu = (ir.opcode == op_addiu);
    assign is_srl   = (ir.opcode == op_special) && (ir.low.r.funct == fn_srl);
    assign is_jr    = (ir.opcode == op_special) && (ir.low.r.funct == fn_jr);

    // anything else falls through as a nop

    assign instr_address = pc;
    assign instr         = ir;

    // operand indexes straight from the latched word
    assign ra = ir.rs;
    assign rb = ir.rt;

    always_comb begin
        if (is_srl) begin
            alu_op = alu_srl;
        end else if (is_addiu) begin
            alu_op = alu_add;
        end else begin
            alu_op = alu_addr;
        end
    end

    // i-type writes back to rt and srl to rd
    assign we    = in_exec && (is_lw || is_addiu || is_srl);
    assign wa    = is_srl ? ir.low.r.rd : ir.rt;
    assign wdata = is_lw ? mem_rdata : result;

    // the memory takes the sw strobe on the same edge
    assign store_valid = in_exec && is_sw;
    assign store.addr  = result;
    assign store.data  = rt_value;

    // instruction register loaded at the end of fetch
    always_ff @(posedge clk) begin
        if (!halted && state == st_fetch) begin
            ir <= instr_readdata;
        end
    end

    // jr target is consumed after the delay slot
    always_ff @(posedge clk) begin
        if (!halted && in_exec && is_jr) begin
            pending_target <= rs_value;
        end
    end

    // sequencing of state, pc and halt
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= st_fetch;
            pc           <= reset_vector;
            pending_jump <= 1'b0;
            halted       <= 1'b0;
        end else if (!halted) begin
            case (state)
                st_fetch: begin
                    state <= st_exec;
                end
                st_exec: begin
                    state <= st_fetch;
                    // the slot instruction has now retired
                    if (pending_jump) begin
                        pc     <= pending_target;
                        halted <= (pending_target == halt_target);
                    end else begin
                        pc <= pc + 32'd4;
                    end
                    // next fetch is the delay slot at pc+4
                    pending_jump <= is_jr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mips_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_top import mips_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // store events and halt level
    output logic   store_valid,
    output store_t store,
    output logic   halted
);

    // fetch path
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;

    // register file
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        we;
    logic [4:0]  wa;
    logic [31:0] wdata;

    // datapath and memory
    alu_op_t     alu_op;
    instr_t      instr;
    logic [31:0] result;
    logic [31:0] mem_rdata;

    cpu_control u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .ra             (ra),
        .rb             (rb),
        .we             (we),
        .wa             (wa),
        .wdata          (wdata),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .alu_op         (alu_op),
        .instr          (instr),
        .result         (result),
        .mem_rdata      (mem_rdata),
        .store_valid    (store_valid),
        .store          (store),
        .halted         (halted)
    );

    srl_2_iram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    // read address is the datapath result, writes come from the store strobe
    data_ram u_dram (
        .clk         (clk),
        .addr        (result),
        .rdata       (mem_rdata),
        .store_valid (store_valid),
        .store       (store)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (ra),
        .rb      (rb),
        .rdata_a (rs_value),
        .rdata_b (rt_value),
        .we      (we),
        .wa      (wa),
        .wdata   (wdata)
    );

    alu_shift u_alu (
        .alu_op   (alu_op),
        .instr    (instr),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== bench/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_tb import mips_pkg::*; ();

    // program shape, 45 instructions of two cycles each
    localparam int store_count     = 14;
    localparam int instr_count     = 45;
    localparam int halt_cycles     = instr_count * 2;
    localparam int reset_cycles    = 16;
    localparam int hold_cycles     = 50;
    localparam int wait_limit      = 200;
    localparam logic [31:0] store_base = 32'h0000_0100;

    logic   clk;
    logic   rst_n;
    logic   store_valid;
    store_t store;
    logic   halted;

    // expected store sequence, filled before reset is released
    logic [31:0] exp_addr [store_count];
    logic [31:0] exp_data [store_count];

    // bookkeeping, all cleared by reset
    int         store_idx;
    int         cycle_cnt;
    logic [4:0] rst_cnt;

    mips_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store       (store),
        .halted      (halted)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // error line for a wrong value, then stop
    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error: %s expected 0x%08h actual 0x%08h", test, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    // any other failure, described in words
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // word k is (k+1)*step, the program shifts it right by k+2
    function automatic logic [31:0] expected_store_data(input int k);
        logic [31:0] word;
        word = 32'(k + 1) * dram_seed_step;
        return word >> (k + 2);
    endfunction

    // counters advance on every rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            store_idx <= 0;
            cycle_cnt <= 0;
            if (rst_cnt != 5'd31) begin
                rst_cnt <= rst_cnt + 5'd1;
            end
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            rst_cnt   <= 5'd0;
            if (store_valid) begin
                store_idx <= store_idx + 1;
            end
        end
    end

    // reset_quiet, skips the very first edge where the core is still unknown
    assert property (@(posedge clk) !rst_n && rst_cnt != 5'd0 |-> !store_valid && !halted)
        else report_failure("store_valid or halted high during reset");

    // reset_quiet on the first edge after release
    assert property (@(posedge clk) $rose(rst_n) |-> !store_valid && !halted)
        else report_failure("store_valid or halted high on first edge after reset");

    // store_addresses
    assert property (@(posedge clk)
        rst_n && store_valid && store_idx < store_count |-> store.addr == exp_addr[store_idx])
        else report_mismatch("store_addresses", exp_addr[$sampled(store_idx)],
                             $sampled(store.addr));

    // store_data, covers lw, srl and sw together
    assert property (@(posedge clk)
        rst_n && store_valid && store_idx < store_count |-> store.data == exp_data[store_idx])
        else report_mismatch("store_data", exp_data[$sampled(store_idx)],
                             $sampled(store.data));

    // no more than 14 pulses per run
    assert property (@(posedge clk) rst_n && store_valid |-> store_idx < store_count)
        else report_failure("more store pulses than the program holds");

    // halt_rule timing, 90 cycles after release
    assert property (@(posedge clk) rst_n && $rose(halted) |-> cycle_cnt == halt_cycles)
        else report_mismatch("halt_rule cycles", 32'(halt_cycles), 32'($sampled(cycle_cnt)));

    // halt_rule, all stores come before the halt
    assert property (@(posedge clk) rst_n && $rose(halted) |-> store_idx == store_count)
        else report_mismatch("halt_rule stores", 32'(store_count), 32'($sampled(store_idx)));

    // halted core is silent
    assert property (@(posedge clk) halted |-> !store_valid)
        else report_failure("store pulse seen while halted");

    // only reset clears the halt
    assert property (@(posedge clk) $fell(halted) |-> !rst_n)
        else report_failure("halted dropped without reset");

    // hold reset low for the full count, release on a falling edge
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (reset_cycles) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
    endtask

    task automatic wait_for_stores(input int count);
        int n;
        n = 0;
        while (store_idx < count && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (store_idx < count) begin
            report_failure("timeout waiting for store pulses");
        end
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        while (!halted && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            report_failure("timeout waiting for halted");
        end
    endtask

    // idle while halted, assertions watch every edge
    task automatic hold_halted();
        repeat (hold_cycles) begin
            @(negedge clk);
        end
        assert (halted)
            else report_failure("halted not held after halt");
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        store_idx = 0;
        cycle_cnt = 0;
        rst_cnt   = 5'd0;
        for (int k = 0; k < store_count; k++) begin
            exp_addr[k] = store_base + 32'(4 * k);
            exp_data[k] = expected_store_data(k);
        end

        // first run, cut short after five stores
        apply_reset();
        wait_for_stores(5);
        // next cycle is a fetch, so no pulse is cut in half
        apply_reset();

        // full run from the mid-run reset
        wait_for_halt();
        hold_halted();

        // reset after halt restarts the whole program
        @(negedge clk);
        apply_reset();
        wait_for_halt();
        hold_halted();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/mips_pkg.sv
logic/srl_2_iram.sv
logic/data_ram.sv
logic/reg_file.sv
logic/alu_shift.sv
logic/cpu_control.sv
logic/mips_top.sv
bench/mips_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mips_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
